/* jy61p_angle.f */
+incdir+tb
source/jy61p_frame_pkg.sv
source/jy61p_bus_pkg.sv
source/uart_byte_rx.sv
source/jy61p_frame_decode.sv
source/jy61p_frame_execute.sv
source/jy61p_result_regs.sv
source/jy61p_angle_top.sv
tb/jy61p_angle_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := jy61p_angle_tb
FILELIST  := jy61p_angle.f
FLAGS     := --binary --timing -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/jy61p_model.svh */
`ifndef JY61P_MODEL_SVH
`define JY61P_MODEL_SVH

// expected state, axes indexed [kind][axis], kind 0 accel 1 gyro 2 angle
logic signed [15:0] exp_axis [3][3];
logic [15:0]        exp_good;
logic [15:0]        exp_bad;
logic [7:0]         frame_bytes [11];   // header, type, eight payload bytes, checksum

function automatic void model_reset();
    for (int k = 0; k < 3; k++) begin
        for (int a = 0; a < 3; a++) begin
            exp_axis[k][a] = 16'sd0;
        end
    end
    exp_good = 16'd0;
    exp_bad  = 16'd0;
endfunction

// payload byte i sits in bits 8*i+7 down to 8*i
function automatic void build_frame(input logic [7:0] type_code, input logic [63:0] payload,
                                    input logic [7:0] flip);
    logic [7:0] sum;
    sum = 8'h55 + type_code;
    frame_bytes[0] = 8'h55;
    frame_bytes[1] = type_code;
    for (int i = 0; i < 8; i++) begin
        frame_bytes[i + 2] = payload[8*i +: 8];
        sum = sum + payload[8*i +: 8];
    end
    frame_bytes[10] = sum ^ flip;   // nonzero flip spoils the checksum
endfunction

function automatic void model_frame(input logic [7:0] type_code, input logic [63:0] payload,
                                    input logic bad);
    int k;
    k = int'(type_code) - 81;   // 0x51 to 0x53 map to kinds 0 to 2
    if (bad) begin
        exp_bad = exp_bad + 16'd1;
    end else if (k >= 0 && k < 3) begin
        for (int a = 0; a < 3; a++) begin
            exp_axis[k][a] = payload[16*a +: 16];   // low byte first on the wire
        end
        exp_good = exp_good + 16'd1;
    end
endfunction

`endif

/* tb/jy61p_angle_tb.sv */
`default_nettype none

module jy61p_angle_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clks_per_bit   = 8;
    localparam int frame_cycles   = 60 * 11 * 10 * 8;
    localparam int max_accesses   = 600;
    localparam int timeout_cycles = 2 * (frame_cycles + 40 * max_accesses);

    logic                   clk;
    logic                   rstn;
    logic                   jy61p_rx;
    jy61p_bus_pkg::wb_req_t wb_req;
    jy61p_bus_pkg::wb_rsp_t wb_rsp;

    int    cycle_cnt;
    int    test_errors;
    int    tests_passed;
    int    tests_failed;
    int    seed_ret;
    string test_name;

    `include "jy61p_model.svh"

    jy61p_angle_top #(
        .clks_per_bit(clks_per_bit)
    ) jy61p_angle_top_i (
        .clk     (clk),
        .rstn    (rstn),
        .jy61p_rx(jy61p_rx),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout, run stopped after %0d cycles", cycle_cnt);
            $display("sim failed");
            $finish;
        end
    end

    task automatic line_bit(input logic v);
        jy61p_rx = v;
        repeat (clks_per_bit) @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] b);
        line_bit(1'b0);   // start
        for (int i = 0; i < 8; i++) begin
            line_bit(b[i]);
        end
        line_bit(1'b1);
    endtask

    // type is 0x51 + k so a k of 3 sends the unkept type 0x54
    task automatic send_kind(input int k, input logic bad);
        logic [63:0] payload;
        logic [7:0]  flip;
        logic [7:0]  type_code;
        payload   = {$urandom, $urandom};
        flip      = bad ? 8'($urandom_range(255, 1)) : 8'd0;
        type_code = 8'h51 + 8'(k);
        build_frame(type_code, payload, flip);
        for (int i = 0; i < 11; i++) begin
            send_byte(frame_bytes[i]);
        end
        model_frame(type_code, payload, bad);
        repeat (3) @(posedge clk);   // stop-bit centre to readable registers
        #1;
    endtask

    task automatic send_junk();
        logic [7:0] b;
        repeat ($urandom_range(3, 1)) begin
            b = 8'($urandom);
            send_byte(b == 8'h55 ? 8'h00 : b);   // never a header
        end
    endtask

    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdata);
        int waited;
        waited       = 0;
        rdata        = 32'd0;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = dat;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_rsp.ack && waited < 4);
        if (wb_rsp.ack) begin
            rdata = wb_rsp.dat_r;
        end else begin
            $display("%s: no ack within 4 cycles at address %0d", test_name, adr);
            test_errors++;
        end
        wb_req = '0;
        @(posedge clk);
        #1;
        if (wb_rsp.ack) begin
            $display("%s: ack stayed high a second cycle at address %0d", test_name, adr);
            test_errors++;
        end
    endtask

    task automatic check_axis(input logic [3:0] adr, input logic signed [15:0] expected,
                              input logic [31:0] actual);
        logic signed [31:0] exp_word;
        exp_word = 32'(expected);   // sign extends
        if (actual !== exp_word) begin
            $display("Mismatch %s reg %0d expected %h actual %h", test_name, adr, exp_word, actual);
            test_errors++;
        end
    endtask

    task automatic check_count(input logic [3:0] adr, input logic [15:0] expected,
                               input logic [31:0] actual);
        if (actual !== {16'd0, expected}) begin
            $display("Mismatch %s reg %0d expected %h actual %h", test_name, adr,
                     {16'd0, expected}, actual);
            test_errors++;
        end
    endtask

    task automatic check_all();
        logic [31:0] rdata;
        for (int adr = 0; adr < 9; adr++) begin
            wb_access(1'b0, 4'(adr), 32'd0, rdata);
            check_axis(4'(adr), exp_axis[adr / 3][adr % 3], rdata);
        end
        wb_access(1'b0, jy61p_bus_pkg::addr_good_cnt, 32'd0, rdata);
        check_count(jy61p_bus_pkg::addr_good_cnt, exp_good, rdata);
        wb_access(1'b0, jy61p_bus_pkg::addr_bad_cnt, 32'd0, rdata);
        check_count(jy61p_bus_pkg::addr_bad_cnt, exp_bad, rdata);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
            tests_passed++;
        end else begin
            $display("%s: %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic [3:0]  clear_adr;
        int          pick;
        clk          = 1'b0;
        rstn         = 1'b0;
        jy61p_rx     = 1'b1;   // idle line
        wb_req       = '0;
        tests_passed = 0;
        tests_failed = 0;
        seed_ret     = $urandom(87);
        model_reset();
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        begin_test("reset_values");
        for (int adr = 0; adr < 16; adr++) begin
            wb_access(1'b0, 4'(adr), 32'd0, rdata);
            check_count(4'(adr), 16'd0, rdata);   // mapped and unmapped alike
        end
        end_test();

        begin_test("angle_frames");
        repeat (6) begin
            send_kind(2, 1'b0);
            check_all();
        end
        end_test();

        begin_test("accel_gyro_frames");
        repeat (8) begin
            send_kind(int'($urandom_range(1, 0)), 1'b0);
            check_all();
        end
        end_test();

        begin_test("bad_checksum");
        repeat (4) begin
            send_kind(int'($urandom_range(2, 0)), 1'b1);
            check_all();
        end
        end_test();

        begin_test("junk_and_unknown_type");
        repeat (4) begin
            send_junk();
            send_kind(3, 1'b0);
            check_all();
            send_junk();
            send_kind(int'($urandom_range(2, 0)), 1'b0);
            check_all();
        end
        end_test();

        // every fifth step clears the good and bad counters in turn
        begin_test("counter_clear_mixed");
        for (int i = 0; i < 20; i++) begin
            if (i % 5 == 4) begin
                clear_adr = (i % 10 == 4) ? jy61p_bus_pkg::addr_good_cnt
                                          : jy61p_bus_pkg::addr_bad_cnt;
                wb_access(1'b1, clear_adr, $urandom, rdata);
                if (clear_adr == jy61p_bus_pkg::addr_good_cnt) begin
                    exp_good = 16'd0;
                end else begin
                    exp_bad = 16'd0;
                end
            end else begin
                pick = int'($urandom_range(4, 0));   // 4 means a corrupted frame
                send_kind(pick == 4 ? int'($urandom_range(3, 0)) : pick, pick == 4);
            end
            check_all();
        end
        end_test();

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/jy61p_angle_top.sv */
`default_nettype none

module jy61p_angle_top #(
    parameter int clks_per_bit = 434   // 50 MHz at 115200 baud
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   jy61p_rx,
    input  jy61p_bus_pkg::wb_req_t wb_req,
    output jy61p_bus_pkg::wb_rsp_t wb_rsp
);

    logic [7:0]               rx_byte;
    logic                     rx_strobe;
    jy61p_frame_pkg::frame_t  frame;
    logic                     frame_valid;
    jy61p_frame_pkg::sample_t sample;

    uart_byte_rx #(
        .clks_per_bit(clks_per_bit)
    ) uart_byte_rx_i (
        .clk      (clk),
        .rstn     (rstn),
        .rxd      (jy61p_rx),
        .rx_byte  (rx_byte),
        .rx_strobe(rx_strobe)
    );

    jy61p_frame_decode jy61p_frame_decode_i (
        .clk        (clk),
        .rstn       (rstn),
        .rx_byte    (rx_byte),
        .rx_strobe  (rx_strobe),
        .frame      (frame),
        .frame_valid(frame_valid)
    );

    jy61p_frame_execute jy61p_frame_execute_i (
        .clk        (clk),
        .rstn       (rstn),
        .frame      (frame),
        .frame_valid(frame_valid),
        .sample     (sample)
    );

    jy61p_result_regs jy61p_result_regs_i (
        .clk   (clk),
        .rstn  (rstn),
        .sample(sample),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

endmodule

`default_nettype wire

/* source/jy61p_result_regs.sv */
`default_nettype none

module jy61p_result_regs (
    input  logic                     clk,
    input  logic                     rstn,
    input  jy61p_frame_pkg::sample_t sample,
    input  jy61p_bus_pkg::wb_req_t   wb_req,
    output jy61p_bus_pkg::wb_rsp_t   wb_rsp
);

    jy61p_frame_pkg::axes_t acc;
    jy61p_frame_pkg::axes_t gyr;
    jy61p_frame_pkg::axes_t ang;
    logic [15:0] good_cnt;
    logic [15:0] bad_cnt;
    logic        req_hit;
    logic        clr_good;
    logic        clr_bad;
    logic        take;
    logic        reject;
    logic [31:0] rd_data;

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    assign req_hit  = wb_req.cyc && wb_req.stb && !wb_rsp.ack;   // first cycle of an access
    assign clr_good = req_hit && wb_req.we && (wb_req.adr == jy61p_bus_pkg::addr_good_cnt);
    assign clr_bad  = req_hit && wb_req.we && (wb_req.adr == jy61p_bus_pkg::addr_bad_cnt);
    assign take     = sample.valid && sample.checksum_ok && sample.known;
    assign reject   = sample.valid && !sample.checksum_ok;

    // all three axes of a kind change together
    always_ff @(posedge clk) begin
        if (!rstn) begin
            acc <= '0;
            gyr <= '0;
            ang <= '0;
        end else if (take) begin
            case (sample.kind)
                jy61p_frame_pkg::kind_accel: acc <= sample.axes;
                jy61p_frame_pkg::kind_gyro:  gyr <= sample.axes;
                jy61p_frame_pkg::kind_angle: ang <= sample.axes;
                default: ;
            endcase
        end
    end

    // host clear beats a same-cycle increment
    always_ff @(posedge clk) begin
        if (!rstn) begin
            good_cnt <= 16'd0;
            bad_cnt  <= 16'd0;
        end else begin
            if (clr_good) begin
                good_cnt <= 16'd0;
            end else if (take) begin
                good_cnt <= good_cnt + 16'd1;
            end
            if (clr_bad) begin
                bad_cnt <= 16'd0;
            end else if (reject) begin
                bad_cnt <= bad_cnt + 16'd1;
            end
        end
    end

    always_comb begin
        case (wb_req.adr)
            jy61p_bus_pkg::addr_acc_x:    rd_data = sext16(acc.x);
            jy61p_bus_pkg::addr_acc_y:    rd_data = sext16(acc.y);
            jy61p_bus_pkg::addr_acc_z:    rd_data = sext16(acc.z);
            jy61p_bus_pkg::addr_gyr_x:    rd_data = sext16(gyr.x);
            jy61p_bus_pkg::addr_gyr_y:    rd_data = sext16(gyr.y);
            jy61p_bus_pkg::addr_gyr_z:    rd_data = sext16(gyr.z);
            jy61p_bus_pkg::addr_roll:     rd_data = sext16(ang.x);
            jy61p_bus_pkg::addr_pitch:    rd_data = sext16(ang.y);
            jy61p_bus_pkg::addr_yaw:      rd_data = sext16(ang.z);
            jy61p_bus_pkg::addr_good_cnt: rd_data = {16'd0, good_cnt};
            jy61p_bus_pkg::addr_bad_cnt:  rd_data = {16'd0, bad_cnt};
            default:                      rd_data = 32'd0;
        endcase
    end

    // single wait state, read data captured with the request
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_rsp.ack <= 1'b0;
        end else begin
            wb_rsp.ack <= req_hit;
            if (req_hit) begin
                wb_rsp.dat_r <= rd_data;
            end
        end
    end

endmodule

`default_nettype wire

/* source/jy61p_frame_execute.sv */
`default_nettype none

module jy61p_frame_execute (
    input  logic                     clk,
    input  logic                     rstn,
    input  jy61p_frame_pkg::frame_t  frame,
    input  logic                     frame_valid,
    output jy61p_frame_pkg::sample_t sample
);

    logic [7:0]                    sum;
    jy61p_frame_pkg::sample_kind_e kind;
    logic                          known;

    // header is part of the checksum even though decode never stores it
    always_comb begin
        sum = jy61p_frame_pkg::frame_header + frame.type_code;
        for (int i = 0; i < 8; i++) begin
            sum = sum + frame.payload.bytes[i];   // wraps mod 256
        end
    end

    always_comb begin
        kind  = jy61p_frame_pkg::kind_accel;
        known = 1'b1;
        case (frame.type_code)
            jy61p_frame_pkg::type_accel: kind = jy61p_frame_pkg::kind_accel;
            jy61p_frame_pkg::type_gyro:  kind = jy61p_frame_pkg::kind_gyro;
            jy61p_frame_pkg::type_angle: kind = jy61p_frame_pkg::kind_angle;
            default:                     known = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sample.valid <= 1'b0;
        end else begin
            sample.valid <= frame_valid;
            if (frame_valid) begin
                sample.kind        <= kind;
                sample.known       <= known;
                sample.checksum_ok <= (sum == frame.checksum);
                sample.axes        <= frame.payload.words.axes;
            end
        end
    end

endmodule

`default_nettype wire

/* source/jy61p_frame_decode.sv */
`default_nettype none

module jy61p_frame_decode (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [7:0]              rx_byte,
    input  logic                    rx_strobe,
    output jy61p_frame_pkg::frame_t frame,
    output logic                    frame_valid
);

    typedef enum logic {
        st_hunt,
        st_collect
    } state_e;

    // byte index after the header: type, eight payload bytes, checksum
    localparam logic [3:0] idx_type  = 4'd0;
    localparam logic [3:0] idx_check = 4'd9;

    state_e     state;
    logic [3:0] byte_idx;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= st_hunt;
            byte_idx    <= idx_type;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (rx_strobe) begin
                case (state)
                    st_hunt: begin
                        if (rx_byte == jy61p_frame_pkg::frame_header) begin
                            state    <= st_collect;
                            byte_idx <= idx_type;
                        end
                    end
                    st_collect: begin
                        if (byte_idx == idx_check) begin
                            state       <= st_hunt;
                            frame_valid <= 1'b1;
                        end else begin
                            byte_idx <= byte_idx + 4'd1;
                        end
                    end
                    default: begin
                        state <= st_hunt;
                    end
                endcase
            end
        end
    end

    // type byte is taken whatever it is; execute sorts it out
    always_ff @(posedge clk) begin
        if (rx_strobe && state == st_collect) begin
            if (byte_idx == idx_type) begin
                frame.type_code <= rx_byte;
            end else if (byte_idx == idx_check) begin
                frame.checksum <= rx_byte;
            end else begin
                frame.payload.bytes[3'(byte_idx - 4'd1)] <= rx_byte;
            end
        end
    end

endmodule

`default_nettype wire

/* source/uart_byte_rx.sv */
`default_nettype none

module uart_byte_rx #(
    parameter int clks_per_bit = 434
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       rxd,
    output logic [7:0] rx_byte,
    output logic       rx_strobe
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
    localparam logic [3:0] stop_bit = 4'd9;

    logic [1:0]       rx_sync;      // two flop synchronizer
    logic             rx_s;
    logic             busy;
    logic             wait_high;    // framing error, hold off until line idles
    logic [3:0]       bit_cnt;      // 0 start, 1..8 data, 9 stop
    logic [cnt_w-1:0] cyc_cnt;
    logic [7:0]       shift;
    logic             sample_now;

    assign rx_s = rx_sync[1];

    // start bit is checked half a bit in, every later bit a full bit after that
    assign sample_now = (bit_cnt == 4'd0) ? (cyc_cnt == half_cnt) : (cyc_cnt == last_cnt);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_sync <= 2'b11;   // idle line level
        end else begin
            rx_sync <= {rx_sync[0], rxd};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy      <= 1'b0;
            wait_high <= 1'b0;
            bit_cnt   <= 4'd0;
            cyc_cnt   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            if (wait_high) begin
                wait_high <= !rx_s;
            end else if (!busy) begin
                if (!rx_s) begin    // falling edge of start bit
                    busy    <= 1'b1;
                    bit_cnt <= 4'd0;
                    cyc_cnt <= '0;
                end
            end else if (!sample_now) begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end else begin
                cyc_cnt <= '0;
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd0) begin
                    if (rx_s) begin
                        busy <= 1'b0;   // glitch, not a start bit
                    end
                end else if (bit_cnt == stop_bit) begin
                    busy <= 1'b0;
                    if (rx_s) begin
                        rx_strobe <= 1'b1;
                    end else begin
                        wait_high <= 1'b1;
                    end
                end
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (busy && sample_now) begin
            if (bit_cnt != 4'd0 && bit_cnt != stop_bit) begin
                shift <= {rx_s, shift[7:1]};
            end
            if (bit_cnt == stop_bit && rx_s) begin
                rx_byte <= shift;
            end
        end
    end

endmodule

`default_nettype wire

/* source/jy61p_bus_pkg.sv */
`default_nettype none

// host side: wishbone classic request and response, register map
package jy61p_bus_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    localparam logic [3:0] addr_acc_x    = 4'd0;
    localparam logic [3:0] addr_acc_y    = 4'd1;
    localparam logic [3:0] addr_acc_z    = 4'd2;
    localparam logic [3:0] addr_gyr_x    = 4'd3;
    localparam logic [3:0] addr_gyr_y    = 4'd4;
    localparam logic [3:0] addr_gyr_z    = 4'd5;
    localparam logic [3:0] addr_roll     = 4'd6;
    localparam logic [3:0] addr_pitch    = 4'd7;
    localparam logic [3:0] addr_yaw      = 4'd8;
    localparam logic [3:0] addr_good_cnt = 4'd9;   // write clears
    localparam logic [3:0] addr_bad_cnt  = 4'd10;  // write clears

endpackage

`default_nettype wire

/* source/jy61p_frame_pkg.sv */
`default_nettype none

// stream side of the JY61P link: frame layout and decoded samples
package jy61p_frame_pkg;

    localparam logic [7:0] frame_header = 8'h55;

    localparam logic [7:0] type_accel = 8'h51;
    localparam logic [7:0] type_gyro  = 8'h52;
    localparam logic [7:0] type_angle = 8'h53;

    // three raw axes, x in the low bits
    typedef struct packed {
        logic signed [15:0] z;
        logic signed [15:0] y;
        logic signed [15:0] x;
    } axes_t;

    // byte k of the payload sits in bytes[k]
    // axis fields run msb to lsb so the first byte on the wire is the low byte of x
    typedef union packed {
        logic [7:0][7:0] bytes;
        struct packed {
            logic [15:0] trailer;    // temperature or version word, unused
            axes_t       axes;
        } words;
    } payload_u;

    typedef struct packed {
        logic [7:0] type_code;
        payload_u   payload;
        logic [7:0] checksum;
    } frame_t;

    typedef enum logic [1:0] {
        kind_accel,
        kind_gyro,
        kind_angle
    } sample_kind_e;

    typedef struct packed {
        logic         valid;        // one cycle pulse
        sample_kind_e kind;
        logic         checksum_ok;
        logic         known;        // type code is one of the three kept
        axes_t        axes;
    } sample_t;

endpackage

`default_nettype wire
